/* tests/core_testdata.mem */
// program image from @00, one word per line, index = (pc - reset_pc) / 4.
// header at @40 (program length, record count, halt pc); records from @43 (test id, rd, data).
@00
00500093  // addi x1, x0, 5
ffd08113  // addi x2, x1, -3
7ff10193  // addi x3, x2, 2047
80018213  // addi x4, x3, -2048
123452b7  // lui x5, 0x12345
00001317  // auipc x6, 0x1
fffff3b7  // lui x7, 0xfffff
06408013  // addi x0, x1, 100
02a00413  // addi x8, x0, 42
002084b3  // add x9, x1, x2
00109493  // slli x9, x1, 1
80000497  // auipc x9, 0x80000
fff48513  // addi x10, x9, -1
00000073  // ecall
00100073  // ebreak
00100593  // addi x11, x0, 1
@40
00000010  // program length
0000000a  // expected write-back records
8000003c  // pc held once halt is up
@43
00000001 00000001 00000005
00000001 00000002 00000002
00000001 00000003 00000801
00000001 00000004 00000001
00000002 00000005 12345000
00000002 00000006 80001014
00000002 00000007 fffff000
00000003 00000008 0000002a
00000004 00000009 0000002c
00000004 0000000a 0000002b

/* sim.f */
common/core_pkg.sv
common/isa_pkg.sv
common/exu_cmd_if.sv
common/regread_if.sv
source/ifu.sv
idu/idu.sv
source/gpr.sv
source/exu.sv
source/rv_core.sv
tests/wb_checker.sv
tests/tb_rv_core.sv

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        halt;

    logic [31:0] testdata [0:127];
    int          prog_len;
    int          cycle_limit;
    int          cycles;
    int          timeout_errors;
    int          value_errors;
    int          other_errors;
    logic        checker_done;

    rv_core dut (
        .clk     (clk),
        .rst     (rst),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .halt    (halt)
    );

    wb_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .halt         (halt),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .done         (checker_done)
    );

    always #10 clk = ~clk;

    // instruction memory model, zero outside the program.
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] index;
        if ($isunknown(addr) || (addr < core_pkg::reset_pc)) begin
            return 32'h0;
        end
        index = (addr - core_pkg::reset_pc) >> 2;
        if (index >= prog_len) begin
            return 32'h0;
        end
        return testdata[index];
    endfunction

    always @(negedge clk) begin
        inst <= fetch_word(pc);
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        inst           = 32'h0;
        cycles         = 0;
        timeout_errors = 0;
        $readmemh("tests/core_testdata.mem", testdata);
        prog_len    = testdata['h40];
        cycle_limit = 2 * prog_len + 20;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (!checker_done && (cycles < cycle_limit)) begin
            @(posedge clk);
            cycles++;
        end
        if (!checker_done) begin
            $display("timeout: the core did not halt within %0d cycles", cycle_limit);
            timeout_errors++;
        end

        // let the last edge's checks settle.
        @(negedge clk);
        $display("error counts: %0d value mismatches, %0d other failures",
                 value_errors, other_errors + timeout_errors);
        if ((value_errors + other_errors + timeout_errors) == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tests/wb_checker.sv */
`timescale 1ns/1ps

module wb_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pc,
    input  logic        wb_en,
    input  logic [4:0]  wb_addr,
    input  logic [31:0] wb_data,
    input  logic        halt,
    output int          value_errors,
    output int          other_errors,
    output logic        done
);

    // layout of the data file.
    localparam int hdr_base    = 'h40;
    localparam int rec_base    = 'h43;
    localparam int hold_cycles = 4;

    logic [31:0] testdata [0:127];
    logic [31:0] halt_pc;
    logic [31:0] exp_pc;
    logic        halt_seen;
    int          rec_count;
    int          rec_idx;
    int          halted_edges;
    string       rec_name;

    function automatic string test_name(input logic [31:0] id);
        case (id)
            32'd1:   return "addi_chain";
            32'd2:   return "lui_auipc";
            32'd3:   return "x0_write";
            32'd4:   return "unsupported";
            default: return "unknown_test";
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    initial begin
        value_errors = 0;
        other_errors = 0;
        done         = 1'b0;
        rec_idx      = 0;
        halted_edges = 0;
        halt_seen    = 1'b0;
        exp_pc       = core_pkg::reset_pc;
        $readmemh("tests/core_testdata.mem", testdata);
        rec_count = testdata[hdr_base + 1];
        halt_pc   = testdata[hdr_base + 2];
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_pc = core_pkg::reset_pc;
        end else begin
            // pc steps by 4 until halt, then holds.
            compare("pc_sequence", exp_pc, pc);
            if (wb_en === 1'b1) begin
                if (halt_seen || halt) begin
                    $display("write-back to x%0d seen after the core halted", wb_addr);
                    other_errors++;
                end else if (rec_idx >= rec_count) begin
                    $display("write-back to x%0d with no expected record left", wb_addr);
                    other_errors++;
                end else begin
                    rec_name = test_name(testdata[rec_base + 3 * rec_idx]);
                    compare({rec_name, " addr"}, testdata[rec_base + 3 * rec_idx + 1],
                            {27'd0, wb_addr});
                    compare({rec_name, " data"}, testdata[rec_base + 3 * rec_idx + 2],
                            wb_data);
                    rec_idx++;
                end
            end else if (wb_en !== 1'b0) begin
                $display("wb_en is unknown at pc %h", pc);
                other_errors++;
            end
            if (halt === 1'b1) begin
                if (!halt_seen) begin
                    halt_seen = 1'b1;
                    compare("ebreak halt_pc", halt_pc, pc);
                    if (rec_idx != rec_count) begin
                        $display("halt reached with %0d expected write-backs unconsumed",
                                 rec_count - rec_idx);
                        other_errors++;
                    end
                end
                halted_edges++;
                if (halted_edges >= hold_cycles) begin
                    done <= 1'b1;
                end
            end else begin
                exp_pc = exp_pc + 32'd4;
            end
        end
    end

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [core_pkg::xlen-1:0]           inst,
    output logic [core_pkg::xlen-1:0]           pc,
    output logic                                wb_en,
    output logic [core_pkg::reg_addr_width-1:0] wb_addr,
    output logic [core_pkg::xlen-1:0]           wb_data,
    output logic                                halt
);

    // decode to execute.
    exu_cmd_if cmd_bus ();
    // decode to register file.
    regread_if rf_bus ();

    ifu u_ifu (
        .clk  (clk),
        .rst  (rst),
        .halt (halt),
        .pc   (pc)
    );

    idu u_idu (
        .inst (inst),
        .pc   (pc),
        .rf   (rf_bus.idu_side),
        .cmd  (cmd_bus.idu_side)
    );

    // write port is fed straight from the execute unit.
    gpr u_gpr (
        .clk   (clk),
        .rst   (rst),
        .rd    (rf_bus.gpr_side),
        .wen   (wb_en),
        .waddr (wb_addr),
        .wdata (wb_data)
    );

    exu u_exu (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd_bus.exu_side),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .halt    (halt)
    );

endmodule

/* source/exu.sv */
`timescale 1ns/1ps

module exu (
    input  logic                                clk,
    input  logic                                rst,
    exu_cmd_if.exu_side                         cmd,
    output logic                                wb_en,
    output logic [core_pkg::reg_addr_width-1:0] wb_addr,
    output logic [core_pkg::xlen-1:0]           wb_data,
    output logic                                halt
);

    logic                      halt_q;
    logic                      writes;
    logic [core_pkg::xlen-1:0] result;

    always_comb begin
        writes = 1'b0;
        result = '0;
        case (cmd.command)
            core_pkg::cmd_add: begin
                writes = 1'b1;
                result = cmd.src1 + cmd.src2;
            end
            core_pkg::cmd_equ: begin
                writes = 1'b1;
                result = cmd.src1;
            end
            default: begin
                writes = 1'b0;
                result = '0;
            end
        endcase
    end

    // write-back, committed by the register file at the next edge.
    assign wb_en   = writes && (cmd.des != 5'd0) && !halt_q;
    assign wb_addr = cmd.des;
    assign wb_data = result;

    // sticky until reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            halt_q <= 1'b0;
        end else if (cmd.command == core_pkg::cmd_halt) begin
            halt_q <= 1'b1;
        end
    end

    assign halt = halt_q;

endmodule

/* source/gpr.sv */
`timescale 1ns/1ps

module gpr (
    input  logic                                clk,
    input  logic                                rst,
    regread_if.gpr_side                         rd,
    input  logic                                wen,
    input  logic [core_pkg::reg_addr_width-1:0] waddr,
    input  logic [core_pkg::xlen-1:0]           wdata
);

    logic [core_pkg::xlen-1:0] regs [0:31];

    // combinational reads, x0 reads zero.
    always_comb begin
        if (rd.raddr1 == 5'd0) begin
            rd.rdata1 = '0;
        end else begin
            rd.rdata1 = regs[rd.raddr1];
        end
    end

    always_comb begin
        if (rd.raddr2 == 5'd0) begin
            rd.rdata2 = '0;
        end else begin
            rd.rdata2 = regs[rd.raddr2];
        end
    end

    // single write port, writes to x0 dropped.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

/* idu/idu.sv */
`timescale 1ns/1ps

module idu (
    input  isa_pkg::inst_t            inst,
    input  logic [core_pkg::xlen-1:0] pc,
    regread_if.idu_side               rf,
    exu_cmd_if.idu_side               cmd
);

    logic is_addi;
    logic is_lui;
    logic is_auipc;
    logic is_ebreak;

    logic rs1_en;
    logic rd_en;

    logic [core_pkg::xlen-1:0] imm_i;
    logic [core_pkg::xlen-1:0] imm_u;
    logic [core_pkg::xlen-1:0] imm;

    // instruction class.
    assign is_addi  = (inst.i_view.opcode == isa_pkg::op_imm) &&
                      (inst.i_view.funct3 == isa_pkg::f3_addi);
    assign is_lui   = (inst.u_view.opcode == isa_pkg::op_lui);
    assign is_auipc = (inst.u_view.opcode == isa_pkg::op_auipc);

    // only the exact ebreak word halts; ecall and csr ops fall to nop.
    assign is_ebreak = (inst.i_view.opcode == isa_pkg::op_system) &&
                       (inst.i_view.funct3 == isa_pkg::f3_priv) &&
                       (inst.i_view.imm12 == isa_pkg::ebreak_imm) &&
                       (inst.i_view.rs1 == 5'd0) &&
                       (inst.i_view.rd == 5'd0);

    // immediates.
    assign imm_i = {{20{inst.i_view.imm12[11]}}, inst.i_view.imm12};
    assign imm_u = {inst.u_view.imm20, 12'h000};

    always_comb begin
        if (is_addi) begin
            imm = imm_i;
        end else if (is_lui || is_auipc) begin
            imm = imm_u;
        end else begin
            imm = '0;
        end
    end

    // register enables.
    assign rs1_en = is_addi;
    assign rd_en  = is_addi || is_lui || is_auipc;

    assign rf.raddr1 = rs1_en ? inst.i_view.rs1 : 5'd0;
    // no supported instruction reads rs2.
    assign rf.raddr2 = 5'd0;
    // rd sits in the same bits for both views.
    assign cmd.des   = rd_en ? inst.i_view.rd : 5'd0;

    // operand and command selection.
    always_comb begin
        cmd.src1    = '0;
        cmd.src2    = '0;
        cmd.command = core_pkg::cmd_nop;
        if (is_addi) begin
            cmd.src1    = imm;
            cmd.src2    = rf.rdata1;
            cmd.command = core_pkg::cmd_add;
        end else if (is_lui) begin
            cmd.src1    = imm;
            cmd.command = core_pkg::cmd_equ;
        end else if (is_auipc) begin
            cmd.src1    = pc;
            cmd.src2    = imm;
            cmd.command = core_pkg::cmd_add;
        end else if (is_ebreak) begin
            cmd.command = core_pkg::cmd_halt;
        end
    end

endmodule

/* source/ifu.sv */
`timescale 1ns/1ps

module ifu (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      halt,
    output logic [core_pkg::xlen-1:0] pc
);

    logic [core_pkg::xlen-1:0] pc_q;
    logic [core_pkg::xlen-1:0] pc_next;

    // sequential fetch only, no branches or jumps.
    always_comb begin
        if (halt) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    // pc moves on the rising edge only.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= core_pkg::reset_pc;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

endmodule

/* common/regread_if.sv */
`timescale 1ns/1ps

interface regread_if;

    // read addresses from the decoder.
    logic [core_pkg::reg_addr_width-1:0] raddr1;
    logic [core_pkg::reg_addr_width-1:0] raddr2;
    // read data, combinational from the register file.
    logic [core_pkg::xlen-1:0]           rdata1;
    logic [core_pkg::xlen-1:0]           rdata2;

    modport idu_side (
        output raddr1,
        output raddr2,
        input  rdata1,
        input  rdata2
    );

    modport gpr_side (
        input  raddr1,
        input  raddr2,
        output rdata1,
        output rdata2
    );

endinterface

/* common/exu_cmd_if.sv */
`timescale 1ns/1ps

interface exu_cmd_if;

    // decoded operands.
    logic [core_pkg::xlen-1:0]           src1;
    logic [core_pkg::xlen-1:0]           src2;
    // destination register, 0 means no write.
    logic [core_pkg::reg_addr_width-1:0] des;
    logic [core_pkg::cmd_width-1:0]      command;

    modport idu_side (
        output src1,
        output src2,
        output des,
        output command
    );

    modport exu_side (
        input src1,
        input src2,
        input des,
        input command
    );

endinterface

/* common/isa_pkg.sv */
package isa_pkg;

    // major opcodes used by this core.
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 values.
    localparam logic [2:0] f3_addi = 3'b000;
    localparam logic [2:0] f3_priv = 3'b000;

    // imm12 field of ebreak, which tells it apart from ecall.
    localparam logic [11:0] ebreak_imm = 12'h001;

    // one instruction word, seen as either I-type or U-type.
    typedef union packed {
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_view;
    } inst_t;

endpackage

/* common/core_pkg.sv */
package core_pkg;

    // datapath widths.
    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;
    localparam int cmd_width      = 4;

    // execute commands carried from decode to execute.
    // no write-back.
    localparam logic [cmd_width-1:0] cmd_nop  = 4'd0;
    // write src1 plus src2.
    localparam logic [cmd_width-1:0] cmd_add  = 4'd1;
    // write src1 unchanged.
    localparam logic [cmd_width-1:0] cmd_equ  = 4'd2;
    // stop the core.
    localparam logic [cmd_width-1:0] cmd_halt = 4'd3;

    // first fetch address out of reset.
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

endpackage
